// ==== dcache_sys.f ====
rtl/bus_pkg.sv
rtl/cache_pkg.sv
rtl/dcache_lookup.sv
rtl/dcache_miss_fsm.sv
rtl/dcache_burst_counter.sv
rtl/dcache_data_ram.sv
rtl/dcache_victim_buffer.sv
rtl/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dcache_sys.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" sim.log; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// ==== tb/tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache;
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int MEM_WORDS  = 1024;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_WAYS   = 2 ** DEF_WAY_BITS;
    localparam int LINE_BYTES = BYTES_PER_WORD * (2 ** DEF_OFFSET_BITS);
    localparam int SET_STRIDE = LINE_BYTES * (2 ** DEF_INDEX_BITS);

    logic   clk;
    logic   resetn;
    logic   dbus_valid;
    logic   dbus_is_write;
    addr_t  dbus_addr;
    wrten_t dbus_write_en;
    word_t  dbus_wdata;
    logic   dbus_addr_ok;
    logic   dbus_data_ok;
    word_t  dbus_rdata;
    logic   cbus_valid;
    logic   cbus_is_write;
    addr_t  cbus_addr;
    word_t  cbus_wdata;
    logic   cbus_okay;
    logic   cbus_last;
    word_t  cbus_rdata;
    logic   gap_en;

    // reference copy of memory as the CPU sees it
    word_t ref_mem [MEM_WORDS];
    int    errors;
    int    timeouts;
    int    wb_checked;
    int    seed;

    dcache_top #(
        .WAY_BITS   (DEF_WAY_BITS),
        .INDEX_BITS (DEF_INDEX_BITS),
        .OFFSET_BITS(DEF_OFFSET_BITS)
    ) u_dcache_top (
        .clk          (clk),
        .resetn       (resetn),
        .dbus_valid   (dbus_valid),
        .dbus_is_write(dbus_is_write),
        .dbus_addr    (dbus_addr),
        .dbus_write_en(dbus_write_en),
        .dbus_wdata   (dbus_wdata),
        .dbus_addr_ok (dbus_addr_ok),
        .dbus_data_ok (dbus_data_ok),
        .dbus_rdata   (dbus_rdata),
        .cbus_valid   (cbus_valid),
        .cbus_is_write(cbus_is_write),
        .cbus_addr    (cbus_addr),
        .cbus_wdata   (cbus_wdata),
        .cbus_okay    (cbus_okay),
        .cbus_last    (cbus_last),
        .cbus_rdata   (cbus_rdata)
    );

    mem_model #(
        .OFFSET_BITS(DEF_OFFSET_BITS),
        .MEM_WORDS  (MEM_WORDS)
    ) u_mem (
        .clk          (clk),
        .gap_en       (gap_en),
        .cbus_valid   (cbus_valid),
        .cbus_is_write(cbus_is_write),
        .cbus_addr    (cbus_addr),
        .cbus_wdata   (cbus_wdata),
        .cbus_okay    (cbus_okay),
        .cbus_last    (cbus_last),
        .cbus_rdata   (cbus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // memory must hold what the CPU last wrote to an evicted line
    task automatic check_writebacks();
        int w;
        for (int k = wb_checked; k < u_mem.wb_addr_q.size(); k++) begin
            w = int'(u_mem.wb_addr_q[k] >> 2);
            if (u_mem.wb_data_q[k] != ref_mem[w]) begin
                errors++;
                $display("** Error at %0t: write-back 0x%h got %h expected %h",
                         $time, u_mem.wb_addr_q[k], u_mem.wb_data_q[k], ref_mem[w]);
            end
        end
        wb_checked = u_mem.wb_addr_q.size();
    endtask

    task automatic wait_cbus_idle();
        int n;
        if (timeouts != 0) return;
        n = 0;
        @(negedge clk);
        while (cbus_valid && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("timeout: memory bus never went idle");
        end
    endtask

    task automatic cpu_access(input logic is_write, input addr_t addr,
                              input wrten_t en, input word_t wdata);
        int    n;
        int    w;
        word_t expected;
        if (timeouts != 0) return;
        w        = int'(addr >> 2);
        expected = ref_mem[w];
        @(posedge clk);
        #2;
        dbus_valid    = 1'b1;
        dbus_is_write = is_write;
        dbus_addr     = addr;
        dbus_write_en = en;
        dbus_wdata    = wdata;
        n = 0;
        @(negedge clk);
        while (!dbus_addr_ok && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("timeout: request to address 0x%h was never accepted", addr);
        end else begin
            // accepted at this edge
            @(posedge clk);
            #2;
            dbus_valid    = 1'b0;
            dbus_is_write = 1'b0;
            dbus_write_en = '0;
            n = 1;
            @(negedge clk);
            while (!dbus_data_ok && n < WAIT_LIMIT) begin
                n++;
                @(negedge clk);
            end
            if (n >= WAIT_LIMIT) begin
                timeouts++;
                $display("timeout: no data for address 0x%h", addr);
            end else begin
                if (n != 1) begin
                    errors++;
                    $display("** Error at %0t: data_ok for 0x%h came %0d cycles after accept",
                             $time, addr, n);
                end
                if (dbus_rdata != expected) begin
                    errors++;
                    $display("** Error at %0t: read 0x%h got %h expected %h",
                             $time, addr, dbus_rdata, expected);
                end
                check_writebacks();
                if (is_write) begin
                    for (int b = 0; b < BYTES_PER_WORD; b++) begin
                        if (en[b]) begin
                            ref_mem[w][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    endtask

    task automatic cold_read_miss();
        int rb0;
        rb0 = u_mem.read_bursts;
        cpu_access(1'b0, 32'h0000_0018, 4'h0, '0);
        wait_cbus_idle();
        if (u_mem.read_bursts != rb0 + 1) begin
            errors++;
            $display("** Error at %0t: cold miss made %0d read bursts",
                     $time, u_mem.read_bursts - rb0);
        end
        // burst starts at the missed word
        if (u_mem.last_read_addr != 32'h0000_0018) begin
            errors++;
            $display("** Error at %0t: fill started at 0x%h expected 0x00000018",
                     $time, u_mem.last_read_addr);
        end
    endtask

    task automatic repeat_read_hit();
        int rb0;
        rb0 = u_mem.read_bursts;
        cpu_access(1'b0, 32'h0000_0014, 4'h0, '0);
        cpu_access(1'b0, 32'h0000_0018, 4'h0, '0);
        if (cbus_valid || u_mem.read_bursts != rb0) begin
            errors++;
            $display("** Error at %0t: hit on a resident line started a burst", $time);
        end
    endtask

    task automatic byte_write_merge();
        cpu_access(1'b1, 32'h0000_0014, 4'b0101, 32'haabb_ccdd);
        cpu_access(1'b0, 32'h0000_0014, 4'h0, '0);
        // old word 5a5a_0005 with bytes 0 and 2 replaced
        if (dbus_rdata != 32'h5abb_00dd) begin
            errors++;
            $display("** Error at %0t: merged word %h expected 5abb00dd", $time, dbus_rdata);
        end
    endtask

    task automatic dirty_eviction();
        int    wb_start;
        int    line_beats;
        addr_t line_a;
        line_a = 32'h0000_0020;
        cpu_access(1'b1, line_a + 32'h4, 4'hf, 32'hdead_beef);
        wb_start = u_mem.wb_addr_q.size();
        for (int k = 1; k <= NUM_WAYS; k++) begin
            cpu_access(1'b0, line_a + addr_t'(k * SET_STRIDE), 4'h0, '0);
        end
        wait_cbus_idle();
        check_writebacks();
        line_beats = 0;
        for (int k = wb_start; k < u_mem.wb_addr_q.size(); k++) begin
            if ((u_mem.wb_addr_q[k] & ~addr_t'(LINE_BYTES - 1)) == line_a) begin
                line_beats++;
            end
        end
        if (line_beats != 2 ** DEF_OFFSET_BITS) begin
            errors++;
            $display("** Error at %0t: dirty line written back with %0d beats",
                     $time, line_beats);
        end
        // refetch from memory
        cpu_access(1'b0, line_a + 32'h4, 4'h0, '0);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        word_t       wdata;
        addr_t       addr;
        gap_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            r     = $random(seed);
            wdata = $random(seed);
            // four tags in each of sets 0 and 3
            addr = addr_t'(int'(r[2:1]) * SET_STRIDE + (r[0] ? 3 : 0) * LINE_BYTES
                           + int'(r[4:3]) * BYTES_PER_WORD);
            cpu_access(r[5], addr, r[9:6], wdata);
        end
        for (int k = 0; k < 8; k++) begin
            for (int wd = 0; wd < 2 ** DEF_OFFSET_BITS; wd++) begin
                addr = addr_t'((k / 2) * SET_STRIDE + ((k % 2) == 1 ? 3 : 0) * LINE_BYTES
                               + wd * BYTES_PER_WORD);
                cpu_access(1'b0, addr, 4'h0, '0);
            end
        end
        wait_cbus_idle();
        check_writebacks();
        gap_en = 1'b0;
    endtask

    initial begin
        errors        = 0;
        timeouts      = 0;
        wb_checked    = 0;
        seed          = 32'h3263_ad66;
        resetn        = 1'b1;
        gap_en        = 1'b0;
        dbus_valid    = 1'b0;
        dbus_is_write = 1'b0;
        dbus_addr     = '0;
        dbus_write_en = '0;
        dbus_wdata    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(i) ^ 32'h5a5a_0000;
        end
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b0;
        cold_read_miss();
        repeat_read_hit();
        byte_write_merge();
        dirty_eviction();
        random_mix();
        finish_run();
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/100ps

module mem_model #(
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS,
    parameter int MEM_WORDS   = 1024
) (
    input  logic           clk,
    input  logic           gap_en,
    input  logic           cbus_valid,
    input  logic           cbus_is_write,
    input  bus_pkg::addr_t cbus_addr,
    input  bus_pkg::word_t cbus_wdata,
    output logic           cbus_okay,
    output logic           cbus_last,
    output bus_pkg::word_t cbus_rdata
);
    import bus_pkg::*;

    localparam int NUM_WORDS = 2 ** OFFSET_BITS;

    word_t mem [MEM_WORDS];
    int    seed;
    int    beat;
    int    read_bursts;
    int    write_bursts;
    addr_t last_read_addr;
    // every write-back beat, byte address and data
    addr_t wb_addr_q [$];
    word_t wb_data_q [$];

    logic  xfer;
    logic  xfer_write;
    addr_t xfer_addr;
    word_t xfer_wdata;

    // word n of a burst, wrapping inside the line
    function automatic int word_index(input addr_t start, input int n);
        int base;
        base = int'(start >> 2);
        return ((base & ~(NUM_WORDS - 1)) | ((base + n) & (NUM_WORDS - 1))) % MEM_WORDS;
    endfunction

    initial begin
        seed           = 32'h3263_ad66;
        beat           = 0;
        read_bursts    = 0;
        write_bursts   = 0;
        last_read_addr = '0;
        cbus_okay      = 1'b0;
        cbus_last      = 1'b0;
        cbus_rdata     = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i) ^ 32'h5a5a_0000;
        end
    end

    always begin
        // bus is stable mid cycle
        @(negedge clk);
        xfer       = cbus_valid && cbus_okay;
        xfer_write = cbus_is_write;
        xfer_addr  = cbus_addr;
        xfer_wdata = cbus_wdata;
        @(posedge clk);
        if (xfer) begin
            if (xfer_write) begin
                mem[word_index(xfer_addr, beat)] = xfer_wdata;
                wb_addr_q.push_back(addr_t'(word_index(xfer_addr, beat) * BYTES_PER_WORD));
                wb_data_q.push_back(xfer_wdata);
            end else if (beat == 0) begin
                last_read_addr = xfer_addr;
            end
            beat = beat + 1;
            if (beat == NUM_WORDS) begin
                beat = 0;
                if (xfer_write) begin
                    write_bursts = write_bursts + 1;
                end else begin
                    read_bursts = read_bursts + 1;
                end
            end
        end
        #2;
        if (cbus_valid) begin
            cbus_okay  = gap_en ? (($random(seed) & 3) != 0) : 1'b1;
            cbus_rdata = mem[word_index(cbus_addr, beat)];
            cbus_last  = beat == NUM_WORDS - 1;
        end else begin
            cbus_okay = 1'b0;
            cbus_last = 1'b0;
        end
    end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top #(
    parameter int WAY_BITS    = cache_pkg::DEF_WAY_BITS,
    parameter int INDEX_BITS  = cache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            dbus_valid,
    input  logic            dbus_is_write,
    input  bus_pkg::addr_t  dbus_addr,
    input  bus_pkg::wrten_t dbus_write_en,
    input  bus_pkg::word_t  dbus_wdata,
    output logic            dbus_addr_ok,
    output logic            dbus_data_ok,
    output bus_pkg::word_t  dbus_rdata,
    output logic            cbus_valid,
    output logic            cbus_is_write,
    output bus_pkg::addr_t  cbus_addr,
    output bus_pkg::word_t  cbus_wdata,
    input  logic            cbus_okay,
    input  logic            cbus_last,
    input  bus_pkg::word_t  cbus_rdata
);
    import bus_pkg::*;

    localparam int ALIGN_BITS = $clog2(BYTES_PER_WORD);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int NUM_WORDS  = 2 ** OFFSET_BITS;

    logic [WAY_BITS-1:0]    hit_way;
    logic                   miss_start;
    logic [WAY_BITS-1:0]    miss_victim_way;
    logic                   miss_victim_dirty;
    logic [TAG_BITS-1:0]    miss_victim_tag;
    logic                   miss_busy;
    logic                   miss_avail;
    logic [WAY_BITS-1:0]    miss_way;
    logic [INDEX_BITS-1:0]  miss_index;
    logic                   fill_beat;
    logic                   victim_capture;
    logic [OFFSET_BITS-1:0] burst_offset;
    logic [NUM_WORDS-1:0]   word_ready;
    word_t                  fill_rdata;

    dcache_lookup #(
        .WAY_BITS   (WAY_BITS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) u_lookup (
        .clk              (clk),
        .resetn           (resetn),
        .dbus_valid       (dbus_valid),
        .dbus_is_write    (dbus_is_write),
        .dbus_addr        (dbus_addr),
        .miss_busy        (miss_busy),
        .miss_avail       (miss_avail),
        .miss_way         (miss_way),
        .miss_index       (miss_index),
        .word_ready       (word_ready),
        .dbus_addr_ok     (dbus_addr_ok),
        .hit_accept       (dbus_data_ok),
        .hit_way          (hit_way),
        .miss_start       (miss_start),
        .miss_victim_way  (miss_victim_way),
        .miss_victim_dirty(miss_victim_dirty),
        .miss_victim_tag  (miss_victim_tag)
    );

    dcache_miss_fsm #(
        .WAY_BITS   (WAY_BITS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) u_miss_fsm (
        .clk              (clk),
        .resetn           (resetn),
        .miss_start       (miss_start),
        .start_addr       (dbus_addr),
        .miss_victim_way  (miss_victim_way),
        .miss_victim_dirty(miss_victim_dirty),
        .miss_victim_tag  (miss_victim_tag),
        .cbus_okay        (cbus_okay),
        .cbus_last        (cbus_last),
        .miss_busy        (miss_busy),
        .miss_avail       (miss_avail),
        .miss_way         (miss_way),
        .miss_index       (miss_index),
        .fill_beat        (fill_beat),
        .victim_capture   (victim_capture),
        .cbus_valid       (cbus_valid),
        .cbus_is_write    (cbus_is_write),
        .cbus_addr        (cbus_addr)
    );

    dcache_burst_counter #(
        .OFFSET_BITS(OFFSET_BITS)
    ) u_burst_counter (
        .clk         (clk),
        .resetn      (resetn),
        .load        (miss_start),
        .start_offset(dbus_addr[ALIGN_BITS +: OFFSET_BITS]),
        .advance     (cbus_okay),
        .burst_offset(burst_offset),
        .word_ready  (word_ready)
    );

    // only accepted writes reach the RAM
    dcache_data_ram #(
        .WAY_BITS   (WAY_BITS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) u_data_ram (
        .clk         (clk),
        .hit_addr    ({hit_way, dbus_addr[ALIGN_BITS +: INDEX_BITS + OFFSET_BITS]}),
        .hit_write_en(dbus_write_en &
                      {BYTES_PER_WORD{dbus_valid && dbus_is_write && dbus_addr_ok}}),
        .hit_wdata   (dbus_wdata),
        .hit_rdata   (dbus_rdata),
        .fill_addr   ({miss_way, miss_index, burst_offset}),
        .fill_write  (fill_beat),
        .fill_wdata  (cbus_rdata),
        .fill_rdata  (fill_rdata)
    );

    dcache_victim_buffer #(
        .OFFSET_BITS(OFFSET_BITS)
    ) u_victim_buffer (
        .clk           (clk),
        .capture       (victim_capture),
        .capture_offset(burst_offset),
        .capture_data  (fill_rdata),
        .read_offset   (burst_offset),
        .wb_data       (cbus_wdata)
    );

endmodule

// ==== rtl/dcache_victim_buffer.sv ====
`timescale 1ns/100ps

module dcache_victim_buffer #(
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS,
    localparam int NUM_WORDS  = 2 ** OFFSET_BITS
) (
    input  logic                   clk,
    input  logic                   capture,
    input  logic [OFFSET_BITS-1:0] capture_offset,
    input  bus_pkg::word_t         capture_data,
    input  logic [OFFSET_BITS-1:0] read_offset,
    output bus_pkg::word_t         wb_data
);
    import bus_pkg::*;

    // one evicted line
    word_t                  line_words [NUM_WORDS];
    logic [OFFSET_BITS-1:0] offset_q;

    always_ff @(posedge clk) begin
        // RAM output lags the beat offset by a cycle
        offset_q <= capture_offset;
        if (capture) begin
            line_words[offset_q] <= capture_data;
        end
    end

    assign wb_data = line_words[read_offset];

endmodule

// ==== rtl/dcache_data_ram.sv ====
`timescale 1ns/100ps

module dcache_data_ram #(
    parameter int WAY_BITS       = cache_pkg::DEF_WAY_BITS,
    parameter int INDEX_BITS     = cache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS    = cache_pkg::DEF_OFFSET_BITS,
    localparam int RAM_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS
) (
    input  logic                     clk,
    input  logic [RAM_ADDR_BITS-1:0] hit_addr,
    input  bus_pkg::wrten_t          hit_write_en,
    input  bus_pkg::word_t           hit_wdata,
    output bus_pkg::word_t           hit_rdata,
    input  logic [RAM_ADDR_BITS-1:0] fill_addr,
    input  logic                     fill_write,
    input  bus_pkg::word_t           fill_wdata,
    output bus_pkg::word_t           fill_rdata
);
    import bus_pkg::*;

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    // way, set, word
    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        // read first on both ports
        hit_rdata  <= mem[hit_addr];
        fill_rdata <= mem[fill_addr];
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (hit_write_en[b]) begin
                mem[hit_addr][8*b +: 8] <= hit_wdata[8*b +: 8];
            end
        end
        // whole word from the fill burst
        if (fill_write) begin
            mem[fill_addr] <= fill_wdata;
        end
    end

endmodule

// ==== rtl/dcache_burst_counter.sv ====
`timescale 1ns/100ps

module dcache_burst_counter #(
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS,
    localparam int NUM_WORDS  = 2 ** OFFSET_BITS
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   load,
    input  logic [OFFSET_BITS-1:0] start_offset,
    input  logic                   advance,
    output logic [OFFSET_BITS-1:0] burst_offset,
    output logic [NUM_WORDS-1:0]   word_ready
);

    always_ff @(posedge clk) begin
        if (resetn) begin
            burst_offset <= '0;
            word_ready   <= '0;
        end else if (load) begin
            // burst begins at the missed word
            burst_offset <= start_offset;
            word_ready   <= '0;
        end else if (advance) begin
            // wraps inside the line
            burst_offset <= OFFSET_BITS'(burst_offset + 1'b1);
            // already all set by the time a write-back runs
            word_ready[burst_offset] <= 1'b1;
        end
    end

endmodule

// ==== rtl/dcache_miss_fsm.sv ====
`timescale 1ns/100ps

module dcache_miss_fsm #(
    parameter int WAY_BITS    = cache_pkg::DEF_WAY_BITS,
    parameter int INDEX_BITS  = cache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS,
    localparam int ALIGN_BITS = $clog2(bus_pkg::BYTES_PER_WORD),
    localparam int TAG_BITS   = bus_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  miss_start,
    input  bus_pkg::addr_t        start_addr,
    input  logic [WAY_BITS-1:0]   miss_victim_way,
    input  logic                  miss_victim_dirty,
    input  logic [TAG_BITS-1:0]   miss_victim_tag,
    input  logic                  cbus_okay,
    input  logic                  cbus_last,
    output logic                  miss_busy,
    output logic                  miss_avail,
    output logic [WAY_BITS-1:0]   miss_way,
    output logic [INDEX_BITS-1:0] miss_index,
    output logic                  fill_beat,
    output logic                  victim_capture,
    output logic                  cbus_valid,
    output logic                  cbus_is_write,
    output bus_pkg::addr_t        cbus_addr
);
    import bus_pkg::*;
    import cache_pkg::*;

    miss_state_t state;
    logic        victim_dirty;
    addr_t       fill_addr;
    addr_t       wb_addr;
    logic        burst_done;

    assign burst_done = cbus_okay && cbus_last;

    assign miss_busy  = state != IDLE;
    // a new miss may start on the last write-back beat
    assign miss_avail = state == IDLE || (state == WRITE && burst_done);
    assign fill_beat  = state == READ && cbus_okay;

    // valid stays high from the fill into the write-back
    assign cbus_valid    = miss_busy;
    assign cbus_is_write = state == WRITE;
    assign cbus_addr     = cbus_is_write ? wb_addr : fill_addr;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state          <= IDLE;
            victim_capture <= 1'b0;
        end else begin
            // old word leaves the RAM one cycle after its beat
            victim_capture <= fill_beat;
            case (state)
                READ: begin
                    if (burst_done) begin
                        state <= victim_dirty ? WRITE : IDLE;
                    end
                end
                WRITE: begin
                    if (burst_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            if (miss_start) begin
                state <= READ;
            end
        end
    end

    // line position and both burst addresses
    always_ff @(posedge clk) begin
        if (miss_start) begin
            victim_dirty <= miss_victim_dirty;
            miss_way     <= miss_victim_way;
            miss_index   <= start_addr[ALIGN_BITS + OFFSET_BITS +: INDEX_BITS];
            fill_addr    <= {start_addr[ADDR_BITS-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
            // same set and starting word, victim tag
            wb_addr      <= {miss_victim_tag,
                             start_addr[ALIGN_BITS +: INDEX_BITS + OFFSET_BITS],
                             {ALIGN_BITS{1'b0}}};
        end
    end

endmodule

// ==== rtl/dcache_lookup.sv ====
`timescale 1ns/100ps

module dcache_lookup #(
    parameter int WAY_BITS    = cache_pkg::DEF_WAY_BITS,
    parameter int INDEX_BITS  = cache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = cache_pkg::DEF_OFFSET_BITS,
    localparam int ALIGN_BITS = $clog2(bus_pkg::BYTES_PER_WORD),
    localparam int TAG_BITS   = bus_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS,
    localparam int NUM_WORDS  = 2 ** OFFSET_BITS
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   dbus_valid,
    input  logic                   dbus_is_write,
    input  bus_pkg::addr_t         dbus_addr,
    input  logic                   miss_busy,
    input  logic                   miss_avail,
    input  logic [WAY_BITS-1:0]    miss_way,
    input  logic [INDEX_BITS-1:0]  miss_index,
    input  logic [NUM_WORDS-1:0]   word_ready,
    output logic                   dbus_addr_ok,
    output logic                   hit_accept,
    output logic [WAY_BITS-1:0]    hit_way,
    output logic                   miss_start,
    output logic [WAY_BITS-1:0]    miss_victim_way,
    output logic                   miss_victim_dirty,
    output logic [TAG_BITS-1:0]    miss_victim_tag
);
    localparam int NUM_WAYS = 2 ** WAY_BITS;
    localparam int NUM_SETS = 2 ** INDEX_BITS;

    // per-set line info
    logic [NUM_WAYS-1:0] valid_bits [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_bits [NUM_SETS];
    logic [TAG_BITS-1:0] tag_store  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-2:0] plru_bits  [NUM_SETS];

    logic [TAG_BITS-1:0]    req_tag;
    logic [INDEX_BITS-1:0]  req_index;
    logic [OFFSET_BITS-1:0] req_offset;
    logic [NUM_WAYS-1:0]    hit_bits;
    logic                   tag_hit;
    logic                   in_miss;
    logic                   req_accept;

    // walk the tree, each node bit points toward the older half
    function automatic logic [WAY_BITS-1:0] plru_victim(input logic [NUM_WAYS-2:0] sel);
        int node;
        logic [WAY_BITS-1:0] way;
        node = 0;
        way  = '0;
        for (int l = 0; l < WAY_BITS; l++) begin
            way[WAY_BITS-1-l] = sel[node];
            node = 2 * node + 1 + int'(sel[node]);
        end
        return way;
    endfunction

    // point every node on the path away from the used way
    function automatic logic [NUM_WAYS-2:0] plru_touch(input logic [NUM_WAYS-2:0] sel,
                                                        input logic [WAY_BITS-1:0] way);
        int node;
        logic [NUM_WAYS-2:0] res;
        node = 0;
        res  = sel;
        for (int l = 0; l < WAY_BITS; l++) begin
            res[node] = ~way[WAY_BITS-1-l];
            node = 2 * node + 1 + int'(way[WAY_BITS-1-l]);
        end
        return res;
    endfunction

    assign req_tag    = dbus_addr[ALIGN_BITS + OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign req_index  = dbus_addr[ALIGN_BITS + OFFSET_BITS +: INDEX_BITS];
    assign req_offset = dbus_addr[ALIGN_BITS +: OFFSET_BITS];

    // compare against every way of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_bits[w] = valid_bits[req_index][w] && tag_store[req_index][w] == req_tag;
            if (hit_bits[w]) begin
                hit_way = hit_way | WAY_BITS'(w);
            end
        end
    end

    assign tag_hit = |hit_bits;

    // the filling line only serves words that have already arrived
    assign in_miss      = miss_busy && hit_way == miss_way && req_index == miss_index;
    assign dbus_addr_ok = tag_hit && (!in_miss || word_ready[req_offset]);
    assign req_accept   = dbus_valid && dbus_addr_ok;
    assign miss_start   = dbus_valid && miss_avail && !tag_hit;

    assign miss_victim_way   = plru_victim(plru_bits[req_index]);
    assign miss_victim_dirty = valid_bits[req_index][miss_victim_way] &&
                               dirty_bits[req_index][miss_victim_way];
    assign miss_victim_tag   = tag_store[req_index][miss_victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit_accept <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
                plru_bits[s]  <= '0;
            end
        end else begin
            // data comes back on the cycle after acceptance
            hit_accept <= req_accept;
            if (req_accept) begin
                plru_bits[req_index] <= plru_touch(plru_bits[req_index], hit_way);
                if (dbus_is_write) begin
                    dirty_bits[req_index][hit_way] <= 1'b1;
                end
            end
            // new line is clean until written
            if (miss_start) begin
                valid_bits[req_index][miss_victim_way] <= 1'b1;
                dirty_bits[req_index][miss_victim_way] <= 1'b0;
                tag_store[req_index][miss_victim_way]  <= req_tag;
            end
        end
    end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } miss_state_t;

    // default geometry, 4 ways x 4 sets x 4 words
    localparam int DEF_WAY_BITS    = 2;
    localparam int DEF_INDEX_BITS  = 2;
    localparam int DEF_OFFSET_BITS = 2;

endpackage

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

    // shared by the processor bus and the memory bus
    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 32;

    // byte lanes per word
    localparam int BYTES_PER_WORD = WORD_BITS / 8;

    // one data word
    typedef logic [WORD_BITS-1:0] word_t;

    // byte address
    typedef logic [ADDR_BITS-1:0] addr_t;

    // one enable bit per byte lane
    typedef logic [BYTES_PER_WORD-1:0] wrten_t;

endpackage
